// File: Makefile
# Verilator build and run of the issue stage testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_issue_stage
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: bench/rs_model.svh
// ----------------------------------------
// cycle model of the station and issue regs
// included inside the testbench module
// ----------------------------------------

`ifndef RS_MODEL_SVH
`define RS_MODEL_SVH

// model table, only busy rows are meaningful
rs_pkg::rs_entry_t m_table [`RS_SIZE];
// what issue_out should hold after the next edge
rs_pkg::issue_t    m_issue [rs_pkg::NUM_CLASS];

// full when every row is busy
function automatic logic all_rows_busy();
	logic full;
	full = 1'b1;
	for (int i = 0; i < `RS_SIZE; i++)
		if (!m_table[i].busy)
			full = 1'b0;
	return full;
endfunction

task automatic clear_model();
	for (int i = 0; i < `RS_SIZE; i++)
		m_table[i] = '0;
	for (int c = 0; c < rs_pkg::NUM_CLASS; c++)
		m_issue[c] = '0;
endtask

// one rising edge with the given inputs
task automatic step_model(input logic fl, input logic dv, input rs_pkg::rs_entry_t de,
		input rs_pkg::cdb_t cb, input logic [rs_pkg::NUM_CLASS-1:0] fb);
	int   slot;
	logic full;
	full = all_rows_busy();
	slot = -1;
	// free slot from the table before this edge, last hit is the highest
	for (int i = 0; i < `RS_SIZE; i++)
		if (!m_table[i].busy)
			slot = i;
	if (fl) begin
		clear_model();
	end else begin
		// wakeup, seen by picking in the same cycle
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (m_table[i].busy && cb.valid && m_table[i].src1_tag == cb.tag)
				m_table[i].src1_rdy = 1'b1;
			if (m_table[i].busy && cb.valid && m_table[i].src2_tag == cb.tag)
				m_table[i].src2_rdy = 1'b1;
		end
		// highest ready row per free class
		for (int c = 0; c < rs_pkg::NUM_CLASS; c++) begin
			m_issue[c] = '0;
			for (int i = `RS_SIZE - 1; i >= 0; i--) begin
				if (!fb[c] && !m_issue[c].valid && m_table[i].busy &&
						m_table[i].src1_rdy && m_table[i].src2_rdy &&
						m_table[i].fu_class == rs_pkg::fu_class_e'(c)) begin
					m_issue[c].valid    = 1'b1;
					m_issue[c].op_id    = m_table[i].op_id;
					m_issue[c].dest_tag = m_table[i].dest_tag;
					m_table[i].busy     = 1'b0;
				end
			end
		end
		// incoming readies taken as given
		if (dv && !full) begin
			m_table[slot]      = de;
			m_table[slot].busy = 1'b1;
		end
	end
endtask

`endif

// File: bench/tb_issue_stage.sv
// ----------------------------------------
// random dispatch, CDB, back-pressure, flush
// checked every cycle against rs_model.svh
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module tb_issue_stage;

	localparam int NUM_CYCLES     = 2000;
	localparam int TIMEOUT_CYCLES = 2 * NUM_CYCLES;

	logic                                   clock;
	logic                                   rst;
	logic                                   flush;
	logic                                   dispatch_valid;
	rs_pkg::rs_entry_t                      dispatch_entry;
	rs_pkg::cdb_t                           cdb;
	logic [rs_pkg::NUM_CLASS-1:0]           fu_busy;
	logic                                   rs_full;
	rs_pkg::issue_t [rs_pkg::NUM_CLASS-1:0] issue_out;

	logic [31:0] lfsr;
	int          op_seq;

	`include "rs_model.svh"

	issue_stage_top dut_i (
		.clock          (clock),
		.rst            (rst),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_entry (dispatch_entry),
		.cdb            (cdb),
		.fu_busy        (fu_busy),
		.rs_full        (rs_full),
		.issue_out      (issue_out)
	);

	// ----------------------------------------
	// helpers
	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	// galois step, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// payload only matters while valid
	task automatic check_outputs();
		assert (rs_full === all_rows_busy())
			else stop_with_error($sformatf("FAILED at %0t: rs_full %b, expected %b",
				$time, rs_full, all_rows_busy()));
		for (int c = 0; c < rs_pkg::NUM_CLASS; c++) begin
			assert (issue_out[c].valid === m_issue[c].valid)
				else stop_with_error($sformatf(
					"FAILED at %0t: class %0d valid %b, expected %b",
					$time, c, issue_out[c].valid, m_issue[c].valid));
			if (m_issue[c].valid) begin
				assert (issue_out[c].op_id === m_issue[c].op_id &&
						issue_out[c].dest_tag === m_issue[c].dest_tag)
					else stop_with_error($sformatf(
						"FAILED at %0t: class %0d op %h dest %h, expected op %h dest %h",
						$time, c, issue_out[c].op_id, issue_out[c].dest_tag,
						m_issue[c].op_id, m_issue[c].dest_tag));
			end
		end
	endtask

	// ----------------------------------------
	// clock and watchdog
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clock);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
				stop_with_error("timeout: test did not finish");
		end
	end

	// ----------------------------------------
	// stimulus, inputs change 1 ns after the edge
	initial begin : stimulus
		logic [31:0] r;
		lfsr           = 32'h324f_6ea4;
		op_seq         = 0;
		rst            = 1'b1;
		flush          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_entry = '0;
		cdb            = '0;
		fu_busy        = '0;
		clear_model();
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;
		for (int n = 0; n < NUM_CYCLES; n++) begin
			check_outputs();
			// about one flush in 64 cycles
			r = rand_bits(6);
			flush = (r[5:0] == 6'h3f);
			dispatch_valid = !all_rows_busy() && (rand_bits(2) != 0);
			// busy bit is random, the DUT must ignore it
			r = rand_bits(3);
			dispatch_entry.busy     = r[2];
			dispatch_entry.fu_class = rs_pkg::fu_class_e'(r[1:0]);
			dispatch_entry.op_id    = `RS_OPID_BITS'(op_seq);
			r = rand_bits(6);
			dispatch_entry.dest_tag = r[5:0];
			// small tag range so the CDB hits often
			r = rand_bits(3);
			dispatch_entry.src1_tag = `RS_TAG_BITS'(r[2:0]);
			dispatch_entry.src1_rdy = (rand_bits(2) != 0);
			r = rand_bits(3);
			dispatch_entry.src2_tag = `RS_TAG_BITS'(r[2:0]);
			dispatch_entry.src2_rdy = (rand_bits(2) != 0);
			r = rand_bits(4);
			cdb.valid = r[3];
			cdb.tag   = `RS_TAG_BITS'(r[2:0]);
			// each class busy a quarter of the time
			for (int c = 0; c < rs_pkg::NUM_CLASS; c++)
				fu_busy[c] = (rand_bits(2) == 0);
			if (dispatch_valid)
				op_seq++;
			step_model(flush, dispatch_valid, dispatch_entry, cdb, fu_busy);
			@(posedge clock);
			#1;
		end
		check_outputs();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/issue_stage_top.sv
// ----------------------------------------
// issue stage, station plus issue registers
// dispatch to issue valid is 2 cycles at best
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module issue_stage_top (
	input  wire                                    clock,
	input  wire                                    rst,
	input  wire                                    flush,
	input  wire                                    dispatch_valid,
	input  wire rs_pkg::rs_entry_t                 dispatch_entry,
	input  wire rs_pkg::cdb_t                      cdb,
	input  wire  [rs_pkg::NUM_CLASS-1:0]           fu_busy,
	output logic                                   rs_full,
	output rs_pkg::issue_t [rs_pkg::NUM_CLASS-1:0] issue_out
);

	// station to issue register
	logic [rs_pkg::NUM_CLASS-1:0]                   grant_valid;
	rs_pkg::rs_entry_t [rs_pkg::NUM_CLASS-1:0]      grant_entry;

	reservation_station u_rs (
		.clock          (clock),
		.rst            (rst),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_entry (dispatch_entry),
		.cdb            (cdb),
		.fu_busy        (fu_busy),
		.rs_full        (rs_full),
		.grant_valid    (grant_valid),
		.grant_entry    (grant_entry)
	);

	rs_issue_reg u_issue (
		.clock       (clock),
		.rst         (rst),
		.flush       (flush),
		.grant_valid (grant_valid),
		.grant_entry (grant_entry),
		.issue_out   (issue_out)
	);

endmodule

`default_nettype wire

// File: rtl/reservation_station.sv
// ----------------------------------------
// entry table with wakeup and per-class select
// CDB does not wake an entry dispatched in the same cycle
// dispatcher must hold dispatch_valid low while rs_full
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module reservation_station (
	input  wire                                            clock,
	input  wire                                            rst,
	input  wire                                            flush,
	input  wire                                            dispatch_valid,
	input  wire rs_pkg::rs_entry_t                         dispatch_entry,
	input  wire rs_pkg::cdb_t                              cdb,
	input  wire  [rs_pkg::NUM_CLASS-1:0]                   fu_busy,
	output logic                                           rs_full,
	output logic [rs_pkg::NUM_CLASS-1:0]                   grant_valid,
	output rs_pkg::rs_entry_t [rs_pkg::NUM_CLASS-1:0]      grant_entry
);

	// registered table and its next state
	rs_pkg::rs_entry_t [`RS_SIZE-1:0] table_q;
	rs_pkg::rs_entry_t [`RS_SIZE-1:0] table_wk;
	rs_pkg::rs_entry_t [`RS_SIZE-1:0] table_d;

	logic [`RS_SIZE-1:0] src1_hit;
	logic [`RS_SIZE-1:0] src2_hit;
	logic [`RS_SIZE-1:0] busy_vec;
	logic [`RS_SIZE-1:0] ready_vec;
	logic [`RS_SIZE-1:0] issued_vec;

	// per class request and grant rows
	logic [rs_pkg::NUM_CLASS-1:0][`RS_SIZE-1:0] cls_req;
	logic [rs_pkg::NUM_CLASS-1:0][`RS_SIZE-1:0] cls_gnt;

	// dispatch slot choice
	logic [`RS_SIZE-1:0] dsp_gnt;
	logic                free_any;
	logic                accept;

	// ----------------------------------------
	// wakeup
	rs_tag_cam u_cam (
		.rs_table (table_q),
		.cdb      (cdb),
		.src1_hit (src1_hit),
		.src2_hit (src2_hit)
	);

	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			table_wk[i]          = table_q[i];
			table_wk[i].src1_rdy = table_q[i].src1_rdy | src1_hit[i];
			table_wk[i].src2_rdy = table_q[i].src2_rdy | src2_hit[i];
			busy_vec[i]          = table_q[i].busy;
			// ready sees this cycle's broadcast
			ready_vec[i] = table_wk[i].busy & table_wk[i].src1_rdy & table_wk[i].src2_rdy;
		end
	end

	// ----------------------------------------
	// select, one picker per class
	for (genvar c = 0; c < rs_pkg::NUM_CLASS; c++) begin : g_cls
		always_comb begin
			for (int i = 0; i < `RS_SIZE; i++) begin
				cls_req[c][i] = ready_vec[i] && !fu_busy[c] &&
					(table_wk[i].fu_class == rs_pkg::fu_class_e'(c));
			end
		end

		rs_pick #(.WIDTH(`RS_SIZE)) u_pick (
			.req (cls_req[c]),
			.gnt (cls_gnt[c]),
			.any (grant_valid[c])
		);
	end

	// mux the granted rows out, zero when idle
	always_comb begin
		issued_vec = '0;
		for (int c = 0; c < rs_pkg::NUM_CLASS; c++) begin
			grant_entry[c] = '0;
			issued_vec     = issued_vec | cls_gnt[c];
			for (int i = 0; i < `RS_SIZE; i++) begin
				if (cls_gnt[c][i])
					grant_entry[c] = table_wk[i];
			end
		end
	end

	// ----------------------------------------
	// dispatch into highest free slot
	rs_pick #(.WIDTH(`RS_SIZE)) u_pick_dsp (
		.req (~busy_vec),
		.gnt (dsp_gnt),
		.any (free_any)
	);

	// full comes from the registered table only
	assign rs_full = ~free_any;
	assign accept  = dispatch_valid & ~rs_full;

	always_comb begin
		table_d = table_wk;
		for (int i = 0; i < `RS_SIZE; i++) begin
			// issued rows leave at this edge
			if (issued_vec[i])
				table_d[i].busy = 1'b0;
			// slot is free so it cannot also be issuing
			if (accept && dsp_gnt[i]) begin
				table_d[i]      = dispatch_entry;
				table_d[i].busy = 1'b1;
			end
		end
	end

	// reset and flush free every row
	always_ff @(posedge clock) begin
		if (rst || flush) begin
			for (int i = 0; i < `RS_SIZE; i++)
				table_q[i].busy <= 1'b0;
		end else begin
			table_q <= table_d;
		end
	end

	// ----------------------------------------
	// checks
	a_no_dispatch_full: assert property (
		@(posedge clock) disable iff (rst) !(dispatch_valid && rs_full))
		else $error("dispatch_valid high while rs_full");

	// rows kept after issue plus exactly the new one
	a_no_overwrite: assert property (
		@(posedge clock) disable iff (rst)
		accept && !flush |=>
			$countones(busy_vec) == $past($countones(busy_vec & ~issued_vec)) + 1)
		else $error("dispatch overwrote a busy entry");

endmodule

`default_nettype wire

// File: rtl/rs_issue_reg.sv
// ----------------------------------------
// one issue register per FU class
// valid lasts one cycle, payload unreset
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rs_issue_reg (
	input  wire                                       clock,
	input  wire                                       rst,
	input  wire                                       flush,
	input  wire  [rs_pkg::NUM_CLASS-1:0]              grant_valid,
	input  wire rs_pkg::rs_entry_t [rs_pkg::NUM_CLASS-1:0] grant_entry,
	output rs_pkg::issue_t [rs_pkg::NUM_CLASS-1:0]    issue_out
);

	always_ff @(posedge clock) begin
		// FUs only need the id and the destination
		for (int c = 0; c < rs_pkg::NUM_CLASS; c++) begin
			issue_out[c].op_id    <= grant_entry[c].op_id;
			issue_out[c].dest_tag <= grant_entry[c].dest_tag;
		end
		if (rst || flush) begin
			for (int c = 0; c < rs_pkg::NUM_CLASS; c++)
				issue_out[c].valid <= 1'b0;
		end else begin
			// idle or busy class loads valid low
			for (int c = 0; c < rs_pkg::NUM_CLASS; c++)
				issue_out[c].valid <= grant_valid[c];
		end
	end

endmodule

`default_nettype wire

// File: rtl/rs_pick.sv
// ----------------------------------------
// fixed priority picker, highest index wins
// grant is one-hot or zero
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_pick #(
	parameter int WIDTH = `RS_SIZE
) (
	input  wire  [WIDTH-1:0] req,
	output logic [WIDTH-1:0] gnt,
	output logic             any
);

	// scan down from the top bit
	always_comb begin : scan
		logic seen;
		seen = 1'b0;
		for (int i = WIDTH - 1; i >= 0; i--) begin
			// a request above this bit blocks it
			gnt[i] = req[i] & ~seen;
			seen = seen | req[i];
		end
	end

	assign any = |req;

	// one row at most, one that asked, and no request above it
	always_comb begin
		assert ($onehot0(gnt) && ((gnt & ~req) == '0) &&
				((req & ~((gnt << 1) - WIDTH'(1))) == '0))
			else $error("rs_pick: bad grant %b for req %b", gnt, req);
	end

endmodule

`default_nettype wire

// File: rtl/rs_pkg.sv
// ----------------------------------------
// shared types of the issue stage
// widths come from rs_settings.svh
// ----------------------------------------

`default_nettype none

`include "rs_settings.svh"

package rs_pkg;

	// functional unit classes, one issue port each
	typedef enum logic [1:0] {
		alu  = 2'd0,
		mem  = 2'd1,
		mult = 2'd2,
		br   = 2'd3
	} fu_class_e;

	// one issue port for every enum value
	localparam int NUM_CLASS = 2 ** $bits(fu_class_e);

	// ----------------------------------------
	// reservation station row
	typedef struct packed {
		logic                     busy;
		fu_class_e                fu_class;
		logic [`RS_OPID_BITS-1:0] op_id;
		logic [`RS_TAG_BITS-1:0]  dest_tag;
		logic [`RS_TAG_BITS-1:0]  src1_tag;
		logic                     src1_rdy;
		logic [`RS_TAG_BITS-1:0]  src2_tag;
		logic                     src2_rdy;
	} rs_entry_t;

	// common data bus broadcast, no acknowledge
	typedef struct packed {
		logic                    valid;
		logic [`RS_TAG_BITS-1:0] tag;
	} cdb_t;

	// what a functional unit gets on issue
	typedef struct packed {
		logic                     valid;
		logic [`RS_OPID_BITS-1:0] op_id;
		logic [`RS_TAG_BITS-1:0]  dest_tag;
	} issue_t;

endpackage

`default_nettype wire

// File: rtl/rs_settings.svh
// ----------------------------------------
// sizes for the station and the tags
// RS_SIZE must be at least 2
// ----------------------------------------

`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// number of reservation station entries
`define RS_SIZE 8

// physical register tag width
`define RS_TAG_BITS 6

// instruction tracking id, passed through to the FUs
`define RS_OPID_BITS 8

`endif

// File: rtl/rs_tag_cam.sv
// ----------------------------------------
// CDB tag match against both sources
// only busy entries can hit
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_tag_cam (
	input  wire rs_pkg::rs_entry_t [`RS_SIZE-1:0] rs_table,
	input  wire rs_pkg::cdb_t                     cdb,
	output logic [`RS_SIZE-1:0]                   src1_hit,
	output logic [`RS_SIZE-1:0]                   src2_hit
);

	// one comparator pair per row
	always_comb begin
		src1_hit = '0;
		src2_hit = '0;
		if (cdb.valid) begin
			for (int i = 0; i < `RS_SIZE; i++) begin
				// free rows keep stale tags, ignore them
				src1_hit[i] = rs_table[i].busy && (rs_table[i].src1_tag == cdb.tag);
				src2_hit[i] = rs_table[i].busy && (rs_table[i].src2_tag == cdb.tag);
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
+incdir+bench
rtl/rs_pkg.sv
rtl/rs_tag_cam.sv
rtl/rs_pick.sv
rtl/reservation_station.sv
rtl/rs_issue_reg.sv
rtl/issue_stage_top.sv
bench/tb_issue_stage.sv
